// File: dcache_sys.f
+incdir+sim
src/cache_pkg.sv
src/dcache_store.sv
src/dcache_lookup.sv
src/main_memory.sv
src/dcache_ctrl.sv
src/dcache_sys.sv
sim/dcache_sys_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_sys_tb -f dcache_sys.f --Mdir obj_dir

# the exit status of the simulation is the result
./obj_dir/Vdcache_sys_tb

// File: sim/dcache_ref.svh
`ifndef DCACHE_REF_SVH
`define DCACHE_REF_SVH

// model of backing memory and cache contents
cache_pkg::word_t            model_mem [MEM_WORDS];
logic [cache_pkg::TAG_W-1:0] model_tag [cache_pkg::SETS][cache_pkg::WAYS];
logic                        model_valid [cache_pkg::SETS][cache_pkg::WAYS];
logic                        model_dirty [cache_pkg::SETS][cache_pkg::WAYS];
cache_pkg::block_t           model_data [cache_pkg::SETS][cache_pkg::WAYS];
logic                        model_mru [cache_pkg::SETS];

function automatic int word_index(logic [31:0] addr);
	return int'(addr[31:2]) % MEM_WORDS;
endfunction

function automatic void reset_model();
	int i;
	int s;
	int w;
	// memory starts as the inverse of each byte address
	for (i = 0; i < MEM_WORDS; i++)
		model_mem[i] = ~cache_pkg::word_t'(i * 4);
	for (s = 0; s < cache_pkg::SETS; s++) begin
		model_mru[s] = 1'b0;
		for (w = 0; w < cache_pkg::WAYS; w++) begin
			model_valid[s][w] = 1'b0;
			model_dirty[s][w] = 1'b0;
		end
	end
endfunction

function automatic void write_back_block(int s, int w);
	int k;
	for (k = 0; k < 2; k++)
		model_mem[word_index({model_tag[s][w], s[2:0], k[0], 2'b00})] = model_data[s][w][k];
	model_dirty[s][w] = 1'b0;
endfunction

function automatic cache_pkg::cpu_resp_t expected_resp(cache_pkg::cpu_req_t r);
	cache_pkg::cpu_resp_t rsp;
	int s;
	int w;
	int b;
	int k;
	s = int'(r.addr.idx);
	b = int'(r.addr.blkoff);
	rsp.hit = 1'b0;
	w = 0;
	for (k = 0; k < cache_pkg::WAYS; k++) begin
		if (model_valid[s][k] && model_tag[s][k] == r.addr.tag) begin
			rsp.hit = 1'b1;
			w = k;
		end
	end
	if (!rsp.hit) begin
		// empty way first or else the least recently used one
		if (!model_valid[s][0])
			w = 0;
		else if (!model_valid[s][1])
			w = 1;
		else
			w = model_mru[s] ? 0 : 1;
		if (model_valid[s][w] && model_dirty[s][w])
			write_back_block(s, w);
		for (k = 0; k < 2; k++)
			model_data[s][w][k] = model_mem[word_index({r.addr.tag, r.addr.idx, k[0], 2'b00})];
		model_tag[s][w] = r.addr.tag;
		model_valid[s][w] = 1'b1;
		model_dirty[s][w] = 1'b0;
	end
	if (r.write) begin
		model_data[s][w][b] = r.wdata;
		model_dirty[s][w] = 1'b1;
	end
	rsp.rdata = model_data[s][w][b];
	model_mru[s] = w[0];
	return rsp;
endfunction

function automatic void flush_model();
	int s;
	int w;
	for (s = 0; s < cache_pkg::SETS; s++) begin
		for (w = 0; w < cache_pkg::WAYS; w++) begin
			if (model_valid[s][w] && model_dirty[s][w])
				write_back_block(s, w);
			model_valid[s][w] = 1'b0;
		end
	end
endfunction

task automatic check_resp(string name, cache_pkg::cpu_resp_t exp, cache_pkg::cpu_resp_t act);
	if (act !== exp) begin
		$display("CHECK FAILED %s: expected rdata %h hit %b, actual rdata %h hit %b",
			name, exp.rdata, exp.hit, act.rdata, act.hit);
		fail_run("response mismatch");
	end
endtask

task automatic check_flushed(string name, logic exp, logic act);
	if (act !== exp) begin
		$display("CHECK FAILED %s: expected flushed %b, actual flushed %b", name, exp, act);
		fail_run("unexpected flushed pulse");
	end
endtask

task automatic check_latency(string name, int exp, int act);
	if (act != exp) begin
		$display("CHECK FAILED %s: expected done in cycle %0d, actual cycle %0d", name, exp, act);
		fail_run("hit latency mismatch");
	end
endtask

`endif

// File: sim/dcache_sys_tb.sv
`default_nettype none

module dcache_sys_tb;

	localparam int MEM_LATENCY = 2;
	localparam int MEM_WORDS   = 256;
	localparam int PERIOD      = 40;
	localparam int DRIVE       = 2;
	localparam int N_RANDOM    = 300;
	// directed sections stay below this count
	localparam int N_DIRECTED  = 64;
	localparam int N_FLUSH     = 1;
	localparam int OP_CYCLES   = 4 * (MEM_LATENCY + 1) + 4;
	localparam int FLUSH_CYCLES = 16 * 40;
	localparam int TIMEOUT = (5 + (N_RANDOM + N_DIRECTED) * OP_CYCLES
		+ N_FLUSH * FLUSH_CYCLES) * PERIOD;

	logic                 CLK;
	logic                 nRST;
	logic                 req_valid;
	cache_pkg::cpu_req_t  req;
	logic                 halt;
	logic                 done;
	cache_pkg::cpu_resp_t resp;
	logic                 flushed;

	int seed;
	int rnd;
	int cyc = 0;
	int issued = 0;
	int answered = 0;
	int flushes_requested = 0;
	int flushes_seen = 0;
	string flush_name;

	// expected responses in request order
	cache_pkg::cpu_resp_t exp_q[$];
	string                name_q[$];
	int                   issue_q[$];

	task automatic fail_run(string why);
		$display("test failed");
		$fatal(1, "%s", why);
	endtask

	`include "dcache_ref.svh"

	dcache_sys #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) UUT (
		.CLK, .nRST, .req_valid, .req, .halt, .done, .resp, .flushed
	);

	always #(PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) cyc <= cyc + 1;

	task automatic issue_access(string name, logic [31:0] addr, logic write,
		cache_pkg::word_t data);
		cache_pkg::cpu_req_t r;
		r.addr = cache_pkg::dcachef_t'(addr);
		r.write = write;
		r.wdata = data;
		@(posedge CLK);
		#DRIVE;
		exp_q.push_back(expected_resp(r));
		name_q.push_back(name);
		issue_q.push_back(cyc);
		issued++;
		req = r;
		req_valid = 1'b1;
		@(posedge CLK);
		#DRIVE;
		req_valid = 1'b0;
		wait (answered == issued);
	endtask

	task automatic request_flush(string name);
		@(posedge CLK);
		#DRIVE;
		flush_model();
		flush_name = name;
		flushes_requested++;
		issued++;
		halt = 1'b1;
		@(posedge CLK);
		#DRIVE;
		halt = 1'b0;
		wait (answered == issued);
	endtask

	// scoreboard samples mid cycle where outputs are stable
	always @(negedge CLK) begin
		if (nRST && done) begin
			if (exp_q.size() == 0) begin
				fail_run("done pulsed with no request outstanding");
			end else begin
				check_resp(name_q[0], exp_q[0], resp);
				// a hit answers one cycle after req_valid is taken
				if (exp_q[0].hit)
					check_latency(name_q[0], issue_q[0] + 1, cyc);
				void'(exp_q.pop_front());
				void'(name_q.pop_front());
				void'(issue_q.pop_front());
				answered++;
			end
		end
		if (nRST && flushed) begin
			check_flushed(flush_name, flushes_requested != flushes_seen, flushed);
			flushes_seen++;
			answered++;
		end
	end

	initial begin
		#(TIMEOUT);
		$display("run timed out after %0d time units with requests still open", TIMEOUT);
		fail_run("watchdog timeout");
	end

	initial begin
		seed = 6;
		CLK = 1'b0;
		nRST = 1'b0;
		req_valid = 1'b0;
		req = '0;
		halt = 1'b0;
		flush_name = "";
		reset_model();
		repeat (5) @(posedge CLK);
		#DRIVE;
		nRST = 1'b1;

		issue_access("cold read miss", 32'h0000_0040, 1'b0, '0);
		issue_access("second word of block", 32'h0000_0044, 1'b0, '0);
		issue_access("repeated read hit", 32'h0000_0040, 1'b0, '0);

		issue_access("write hit", 32'h0000_0044, 1'b1, 32'hA5A5_0001);
		issue_access("read after write hit", 32'h0000_0044, 1'b0, '0);
		issue_access("write miss merge", 32'h0000_0088, 1'b1, 32'h5A5A_0002);
		issue_access("other word after merge", 32'h0000_008C, 1'b0, '0);
		issue_access("merged word", 32'h0000_0088, 1'b0, '0);

		// set 2 with tags 0, 1 and 2
		issue_access("evict fill way 0", 32'h0000_0010, 1'b1, 32'hDEAD_0003);
		issue_access("evict fill way 1", 32'h0000_0050, 1'b0, '0);
		issue_access("evict touch way 0", 32'h0000_0010, 1'b0, '0);
		issue_access("evict clean lru", 32'h0000_0090, 1'b0, '0);
		issue_access("evict dirty lru", 32'h0000_0050, 1'b0, '0);
		issue_access("reread written back", 32'h0000_0010, 1'b0, '0);

		for (int i = 0; i < N_RANDOM; i++) begin
			rnd = $random(seed);
			issue_access("random mix", {24'b0, rnd[7:2], 2'b00}, rnd[8], $random(seed));
		end

		request_flush("halt flush");

		// one read per block and each one a miss
		for (int b = 0; b < 32; b++) begin
			issue_access("read after flush", {24'b0, b[4:0], b[0], 2'b00}, 1'b0, '0);
		end

		// room for a stray done or flushed pulse to show up
		repeat (2) @(posedge CLK);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// field widths and counts
	parameter int WORD_W = 32;
	parameter int ADDR_W = 32;
	parameter int TAG_W  = 26;
	parameter int IDX_W  = 3;
	parameter int BLK_W  = 1;
	parameter int SETS   = 8;
	parameter int WAYS   = 2;

	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits at the lower address
	typedef word_t [1:0] block_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic [BLK_W-1:0] blkoff;
		logic [1:0]       bytoff;
	} dcachef_t;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		dcachef_t addr;
		logic     write;
		word_t    wdata;
	} cpu_req_t;

	typedef struct packed {
		word_t rdata;
		logic  hit;
	} cpu_resp_t;

	typedef struct packed {
		logic              ren;
		logic              wen;
		logic [ADDR_W-1:0] addr;
		word_t             store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_resp_t;

	// payload goes on the store's own typed port
	typedef struct packed {
		logic             en;
		logic [IDX_W-1:0] idx;
		logic             way;
	} store_wr_t;

endpackage

`default_nettype wire

// File: src/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
	input  logic                                    CLK,
	input  logic                                    nRST,
	input  logic                                    req_valid,
	input  cache_pkg::cpu_req_t                     req,
	input  logic                                    halt,
	output logic                                    done,
	output cache_pkg::cpu_resp_t                    resp,
	output logic                                    flushed,
	output cache_pkg::dcachef_t                     lk_addr,
	input  logic                                    hit,
	input  logic                                    hit_way,
	input  logic                                    victim_way,
	input  cache_pkg::tag_entry_t                   victim_entry,
	output logic                                    touch,
	output logic                                    touch_way,
	output logic [cache_pkg::IDX_W-1:0]             rd_set,
	input  cache_pkg::tag_entry_t [cache_pkg::WAYS-1:0] tag_rd,
	input  cache_pkg::block_t [cache_pkg::WAYS-1:0] data_rd,
	output cache_pkg::store_wr_t                    tag_wr,
	output cache_pkg::store_wr_t                    data_wr,
	output cache_pkg::tag_entry_t                   tag_wdata,
	output cache_pkg::block_t                       data_wdata,
	output cache_pkg::mem_req_t                     mem_req,
	input  cache_pkg::mem_resp_t                    mem_resp
);

	typedef enum logic [3:0] {
		IDLE, LOOKUP, WB0, WB1, FETCH0, FETCH1, MERGE,
		FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1, FLUSH_DONE
	} state_t;

	state_t state, next_state;

	cache_pkg::cpu_req_t req_q;
	cache_pkg::word_t    fill_word;
	logic                way_q;
	logic                sel_way;
	logic                ready;
	logic                slot_inc;

	// flush slot is {way, set}
	logic [cache_pkg::IDX_W:0]   slot;
	logic [cache_pkg::IDX_W-1:0] slot_set;
	logic                        slot_way;
	cache_pkg::tag_entry_t       slot_entry;
	cache_pkg::block_t           merged;

	assign {slot_way, slot_set} = slot;
	assign slot_entry = tag_rd[slot_way];
	assign ready = !mem_resp.dwait;
	assign lk_addr = req_q.addr;

	// hit way while looking up and the latched victim afterwards
	assign sel_way = (state == LOOKUP) ? hit_way : way_q;

	always_comb begin
		merged = data_rd[sel_way];
		merged[req_q.addr.blkoff] = req_q.wdata;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			slot <= '0;
			way_q <= 1'b0;
		end else begin
			state <= next_state;
			if (state == IDLE && halt)
				slot <= '0;
			else if (slot_inc)
				slot <= slot + 1'b1;
			if (state == LOOKUP && !hit)
				way_q <= victim_way;
		end
	end

	always_ff @(posedge CLK) begin
		if (state == IDLE && req_valid)
			req_q <= req;
		if (state == FETCH0 && ready)
			fill_word <= mem_resp.load;
	end

	always_comb begin
		next_state = state;
		slot_inc = 1'b0;
		done = 1'b0;
		flushed = 1'b0;
		touch = 1'b0;
		touch_way = sel_way;
		tag_wr = '0;
		data_wr = '0;
		tag_wdata = '{valid: 1'b1, dirty: 1'b0, tag: req_q.addr.tag};
		data_wdata = merged;
		mem_req = '0;
		rd_set = req_q.addr.idx;
		// writes echo their own data back
		resp.rdata = req_q.write ? req_q.wdata : data_rd[sel_way][req_q.addr.blkoff];
		resp.hit = (state == LOOKUP);

		case (state)
			IDLE: begin
				if (halt)
					next_state = FLUSH_SCAN;
				else if (req_valid)
					next_state = LOOKUP;
			end
			LOOKUP: begin
				if (hit) begin
					done = 1'b1;
					touch = 1'b1;
					next_state = IDLE;
					if (req_q.write) begin
						data_wr = '{en: 1'b1, idx: req_q.addr.idx, way: hit_way};
						tag_wr = '{en: 1'b1, idx: req_q.addr.idx, way: hit_way};
						tag_wdata.dirty = 1'b1;
					end
				end else if (victim_entry.valid && victim_entry.dirty) begin
					next_state = WB0;
				end else begin
					next_state = FETCH0;
				end
			end
			WB0, WB1: begin
				mem_req.wen = 1'b1;
				mem_req.addr = {victim_entry.tag, req_q.addr.idx, state == WB1, 2'b00};
				mem_req.store = data_rd[way_q][state == WB1];
				if (ready)
					next_state = (state == WB0) ? WB1 : FETCH0;
			end
			FETCH0, FETCH1: begin
				mem_req.ren = 1'b1;
				mem_req.addr = {req_q.addr.tag, req_q.addr.idx, state == FETCH1, 2'b00};
				if (ready && state == FETCH0) begin
					next_state = FETCH1;
				end else if (ready) begin
					// whole block lands at once and clean
					data_wdata[0] = fill_word;
					data_wdata[1] = mem_resp.load;
					data_wr = '{en: 1'b1, idx: req_q.addr.idx, way: way_q};
					tag_wr = '{en: 1'b1, idx: req_q.addr.idx, way: way_q};
					next_state = MERGE;
				end
			end
			MERGE: begin
				done = 1'b1;
				touch = 1'b1;
				next_state = IDLE;
				if (req_q.write) begin
					data_wr = '{en: 1'b1, idx: req_q.addr.idx, way: way_q};
					tag_wr = '{en: 1'b1, idx: req_q.addr.idx, way: way_q};
					tag_wdata.dirty = 1'b1;
				end
			end
			FLUSH_SCAN: begin
				rd_set = slot_set;
				if (slot_entry.valid && slot_entry.dirty)
					next_state = FLUSH_WB0;
				else if (&slot)
					next_state = FLUSH_DONE;
				else
					slot_inc = 1'b1;
			end
			FLUSH_WB0, FLUSH_WB1: begin
				rd_set = slot_set;
				mem_req.wen = 1'b1;
				mem_req.addr = {slot_entry.tag, slot_set, state == FLUSH_WB1, 2'b00};
				mem_req.store = data_rd[slot_way][state == FLUSH_WB1];
				if (ready && state == FLUSH_WB0) begin
					next_state = FLUSH_WB1;
				end else if (ready) begin
					next_state = (&slot) ? FLUSH_DONE : FLUSH_SCAN;
					slot_inc = !(&slot);
				end
			end
			FLUSH_DONE: begin
				// stores are emptied on this same cycle
				flushed = 1'b1;
				next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: src/dcache_lookup.sv
`default_nettype none

module dcache_lookup (
	input  logic                                        CLK,
	input  logic                                        nRST,
	input  cache_pkg::dcachef_t                         addr,
	input  cache_pkg::tag_entry_t [cache_pkg::WAYS-1:0] entries,
	input  logic                                        touch,
	input  logic                                        touch_way,
	output logic                                        hit,
	output logic                                        hit_way,
	output logic                                        victim_way,
	output cache_pkg::tag_entry_t                       victim_entry
);

	// the way used most recently in each set
	logic [cache_pkg::SETS-1:0] mru;
	logic [cache_pkg::WAYS-1:0] match;

	always_comb begin
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			match[w] = entries[w].valid && (entries[w].tag == addr.tag);
		end
	end

	assign hit = |match;
	assign hit_way = match[1];

	// fill empty ways first with way 0 before way 1
	always_comb begin
		if (!entries[0].valid)
			victim_way = 1'b0;
		else if (!entries[1].valid)
			victim_way = 1'b1;
		else
			victim_way = !mru[addr.idx];
	end

	assign victim_entry = entries[victim_way];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			mru <= '0;
		else if (touch)
			mru[addr.idx] <= touch_way;
	end

endmodule

`default_nettype wire

// File: src/dcache_store.sv
`default_nettype none

module dcache_store #(
	parameter type entry_t = logic
) (
	input  logic                          CLK,
	input  logic                          nRST,
	input  logic [cache_pkg::IDX_W-1:0]   rd_set,
	output entry_t [cache_pkg::WAYS-1:0]  rd,
	input  cache_pkg::store_wr_t          wr,
	input  entry_t                        wdata,
	input  logic                          clear
);

	// one row per set, one column per way
	entry_t [cache_pkg::WAYS-1:0] mem [cache_pkg::SETS];

	// both ways of the chosen set with no read latency
	assign rd = mem[rd_set];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < cache_pkg::SETS; s++) begin
				mem[s] <= '0;
			end
		end else if (clear) begin
			// everything goes invalid at once when a flush ends
			for (int s = 0; s < cache_pkg::SETS; s++) begin
				mem[s] <= '0;
			end
		end else if (wr.en) begin
			mem[wr.idx][wr.way] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/dcache_sys.sv
`default_nettype none

module dcache_sys #(
	parameter int MEM_LATENCY = 2,
	parameter int MEM_WORDS   = 256
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  req_valid,
	input  cache_pkg::cpu_req_t   req,
	input  logic                  halt,
	output logic                  done,
	output cache_pkg::cpu_resp_t  resp,
	output logic                  flushed
);

	cache_pkg::dcachef_t                         lk_addr;
	logic                                        hit;
	logic                                        hit_way;
	logic                                        victim_way;
	cache_pkg::tag_entry_t                       victim_entry;
	logic                                        touch;
	logic                                        touch_way;
	logic [cache_pkg::IDX_W-1:0]                 rd_set;
	cache_pkg::tag_entry_t [cache_pkg::WAYS-1:0] tag_rd;
	cache_pkg::block_t [cache_pkg::WAYS-1:0]     data_rd;
	cache_pkg::store_wr_t                        tag_wr;
	cache_pkg::store_wr_t                        data_wr;
	cache_pkg::tag_entry_t                       tag_wdata;
	cache_pkg::block_t                           data_wdata;
	cache_pkg::mem_req_t                         mem_req;
	cache_pkg::mem_resp_t                        mem_resp;

	dcache_ctrl ctrl (
		.CLK, .nRST, .req_valid, .req, .halt, .done, .resp, .flushed,
		.lk_addr, .hit, .hit_way, .victim_way, .victim_entry,
		.touch, .touch_way, .rd_set, .tag_rd, .data_rd,
		.tag_wr, .data_wr, .tag_wdata, .data_wdata,
		.mem_req, .mem_resp
	);

	// flushed doubles as the clear of both stores
	dcache_store #(.entry_t(cache_pkg::tag_entry_t)) tag_store (
		.CLK, .nRST, .rd_set, .rd(tag_rd), .wr(tag_wr), .wdata(tag_wdata), .clear(flushed)
	);

	dcache_store #(.entry_t(cache_pkg::block_t)) data_store (
		.CLK, .nRST, .rd_set, .rd(data_rd), .wr(data_wr), .wdata(data_wdata), .clear(flushed)
	);

	dcache_lookup lookup (
		.CLK, .nRST, .addr(lk_addr), .entries(tag_rd), .touch, .touch_way,
		.hit, .hit_way, .victim_way, .victim_entry
	);

	main_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) memory (
		.CLK, .nRST, .req(mem_req), .resp(mem_resp)
	);

endmodule

`default_nettype wire

// File: src/main_memory.sv
`default_nettype none

module main_memory #(
	parameter int MEM_LATENCY = 2,
	parameter int MEM_WORDS   = 256
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  cache_pkg::mem_req_t   req,
	output cache_pkg::mem_resp_t  resp
);

	localparam int AW    = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(MEM_LATENCY + 2);

	cache_pkg::word_t mem [MEM_WORDS];
	logic [CNT_W-1:0] cnt;
	logic [AW-1:0]    waddr;
	logic             active;
	logic             ready;

	// word address with the byte offset dropped
	assign waddr = req.addr[2 +: AW];
	assign active = req.ren || req.wen;
	assign ready = active && (cnt == CNT_W'(MEM_LATENCY));

	assign resp.dwait = !ready;
	assign resp.load = mem[waddr];

	// counts the wait cycles of the word being held
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			cnt <= '0;
		else if (!active || ready)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// each word starts as the inverse of its byte address
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= ~(cache_pkg::word_t'(i) << 2);
			end
		end else if (ready && req.wen) begin
			mem[waddr] <= req.store;
		end
	end

endmodule

`default_nettype wire
